// ==== include/gcn_cfg.svh ====
`ifndef GCN_CFG_SVH
`define GCN_CFG_SVH

// graph shape
`define GCN_NODES      6
`define GCN_EDGES      6
`define GCN_FEATS      4
`define GCN_CLASSES    3

// data widths
`define GCN_FEAT_W     5
`define GCN_NODE_W     3
`define GCN_AGG_W      8

// four products of agg by weight still fit
`define GCN_SCORE_W    15

// aggregated columns held between producer and consumer
`define GCN_FIFO_DEPTH 2

`endif

// ==== logic/gcn_pkg.sv ====
`include "gcn_cfg.svh"

package gcn_pkg;

    // scalar types
    typedef logic [`GCN_NODE_W-1:0]            node_id_t;
    typedef logic [`GCN_FEAT_W-1:0]            feat_t;
    typedef logic [`GCN_AGG_W-1:0]             agg_t;
    typedef logic [`GCN_SCORE_W-1:0]           score_t;
    typedef logic [$clog2(`GCN_CLASSES)-1:0]   class_t;
    typedef logic [$clog2(`GCN_FEATS)-1:0]     feat_addr_t;

    // adjacency, bit k of row n set when nodes n+1 and k+1 share an edge
    typedef logic [`GCN_NODES-1:0]             adj_row_t;
    typedef adj_row_t [`GCN_NODES-1:0]         adj_mat_t;

    // column and row words, element n belongs to node n+1
    typedef feat_t [`GCN_NODES-1:0]            feat_col_t;
    typedef agg_t [`GCN_NODES-1:0]             agg_col_t;

    // one weight per class
    typedef feat_t [`GCN_CLASSES-1:0]          weight_row_t;

endpackage

// ==== logic/agg_col_if.sv ====
`timescale 1ns/1ps

interface agg_col_if;

    logic               push;
    gcn_pkg::agg_col_t  push_col;
    logic               full;
    logic               pop;
    gcn_pkg::agg_col_t  pop_col;
    logic               empty;

    // aggregator side
    modport producer (
        output push,
        output push_col,
        input  full
    );

    modport buffer (
        input  push,
        input  push_col,
        input  pop,
        output full,
        output pop_col,
        output empty
    );

    // scorer side, pop_col valid while empty is low
    modport consumer (
        output pop,
        input  pop_col,
        input  empty
    );

endinterface

// ==== logic/adjacency_builder.sv ====
`timescale 1ns/1ps
`include "gcn_cfg.svh"

module adjacency_builder (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  gcn_pkg::node_id_t [`GCN_EDGES-1:0] coo_src,
    input  gcn_pkg::node_id_t [`GCN_EDGES-1:0] coo_dst,
    output gcn_pkg::adj_mat_t                  adj,
    output logic                               adj_done
);

    localparam int edge_idx_w = $clog2(`GCN_EDGES);

    gcn_pkg::node_id_t [`GCN_EDGES-1:0] src_r;
    gcn_pkg::node_id_t [`GCN_EDGES-1:0] dst_r;
    logic [edge_idx_w-1:0]              edge_idx;
    logic                               busy;
    gcn_pkg::node_id_t                  cur_src;
    gcn_pkg::node_id_t                  cur_dst;
    logic                               edge_ok;
    logic                               ids_ok;

    // edge list snapshot
    always_ff @(posedge clk) begin
        if (start) begin
            src_r <= coo_src;
            dst_r <= coo_dst;
        end
    end

    assign cur_src = src_r[edge_idx];
    assign cur_dst = dst_r[edge_idx];
    // a zero id marks an unused slot
    assign edge_ok = (cur_src != '0) && (cur_dst != '0);

    // one edge per cycle, ids are 1-based
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj      <= '0;
            adj_done <= 1'b0;
            busy     <= 1'b0;
            edge_idx <= '0;
        end else begin
            adj_done <= 1'b0;
            if (start) begin
                adj      <= '0;
                busy     <= 1'b1;
                edge_idx <= '0;
            end else if (busy) begin
                if (edge_ok) begin
                    adj[cur_src - 1'b1][cur_dst - 1'b1] <= 1'b1;
                    adj[cur_dst - 1'b1][cur_src - 1'b1] <= 1'b1;
                end
                if (edge_idx == edge_idx_w'(`GCN_EDGES - 1)) begin
                    busy     <= 1'b0;
                    adj_done <= 1'b1;
                end else begin
                    edge_idx <= edge_idx + 1'b1;
                end
            end
        end
    end

    always_comb begin
        ids_ok = 1'b1;
        for (int e = 0; e < `GCN_EDGES; e++) begin
            if ((coo_src[e] > `GCN_NODES) || (coo_dst[e] > `GCN_NODES)) begin
                ids_ok = 1'b0;
            end
        end
    end

    a_ids_in_range: assert property (@(posedge clk) disable iff (!rst_n) start |-> ids_ok)
        else $error("edge id above node count at start");

endmodule

// ==== logic/neighbor_aggregator.sv ====
`timescale 1ns/1ps
`include "gcn_cfg.svh"

module neighbor_aggregator (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                adj_done,
    input  gcn_pkg::adj_mat_t   adj,
    input  gcn_pkg::feat_col_t  feat_col,
    output logic                feat_re,
    output gcn_pkg::feat_addr_t feat_addr,
    agg_col_if.producer         agg
);

    // split point of the two-level adder
    localparam int half = `GCN_NODES / 2;

    gcn_pkg::feat_addr_t col_cnt;
    logic                active;
    logic                pending;
    logic                col_vld;
    logic                sum_vld;
    gcn_pkg::agg_col_t   part_a;
    gcn_pkg::agg_col_t   part_b;
    gcn_pkg::agg_col_t   part_a_nxt;
    gcn_pkg::agg_col_t   part_b_nxt;

    ////////////////////
    // read sequencing
    ////////////////////

    // pending stays up from the read until its column is pushed
    assign feat_re   = active && !pending && !agg.full;
    assign feat_addr = col_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            col_cnt <= '0;
            pending <= 1'b0;
            col_vld <= 1'b0;
            sum_vld <= 1'b0;
        end else begin
            col_vld <= feat_re;
            sum_vld <= col_vld;
            if (adj_done) begin
                active  <= 1'b1;
                col_cnt <= '0;
            end else if (feat_re) begin
                col_cnt <= col_cnt + 1'b1;
                if (col_cnt == gcn_pkg::feat_addr_t'(`GCN_FEATS - 1)) begin
                    active <= 1'b0;
                end
            end
            if (feat_re) begin
                pending <= 1'b1;
            end else if (sum_vld) begin
                pending <= 1'b0;
            end
        end
    end

    ////////////////////
    // masked sums
    ////////////////////

    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            part_a_nxt[n] = '0;
            part_b_nxt[n] = '0;
            for (int k = 0; k < `GCN_NODES; k++) begin
                // adjacency row n picks the neighbours of node n
                if (adj[n][k] && (k < half)) begin
                    part_a_nxt[n] = part_a_nxt[n] + gcn_pkg::agg_t'(feat_col[k]);
                end else if (adj[n][k]) begin
                    part_b_nxt[n] = part_b_nxt[n] + gcn_pkg::agg_t'(feat_col[k]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (col_vld) begin
            part_a <= part_a_nxt;
            part_b <= part_b_nxt;
        end
    end

    // second adder level feeds the buffer directly
    assign agg.push = sum_vld;

    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            agg.push_col[n] = part_a[n] + part_b[n];
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) agg.push |-> !agg.full)
        else $error("aggregated column pushed into a full buffer");

endmodule

// ==== logic/agg_col_fifo.sv ====
`timescale 1ns/1ps
`include "gcn_cfg.svh"

module agg_col_fifo (
    input logic       clk,
    input logic       rst_n,
    agg_col_if.buffer agg
);

    localparam int depth = `GCN_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    gcn_pkg::agg_col_t mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              do_push;
    logic              do_pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        ptr_inc = (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push     = agg.push && !agg.full;
    assign do_pop      = agg.pop && !agg.empty;
    assign agg.full    = (count == cnt_w'(depth));
    assign agg.empty   = (count == '0);
    // head entry
    assign agg.pop_col = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= agg.push_col;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) agg.pop |-> !agg.empty)
        else $error("column popped from an empty buffer");

endmodule

// ==== logic/class_scorer.sv ====
`timescale 1ns/1ps
`include "gcn_cfg.svh"

module class_scorer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  gcn_pkg::weight_row_t                wt_row,
    output logic                                wt_re,
    output gcn_pkg::feat_addr_t                 wt_addr,
    output gcn_pkg::class_t [`GCN_NODES-1:0]    y,
    output logic                                done,
    agg_col_if.consumer                         agg
);

    localparam int cnt_w = $clog2(`GCN_FEATS + 1);

    logic [cnt_w-1:0]                 take_cnt;
    logic [cnt_w-1:0]                 acc_cnt;
    logic                             mac_vld;
    logic                             scan_act;
    logic                             last_acc;
    logic                             last_cls;
    gcn_pkg::class_t                  cls_cnt;
    gcn_pkg::agg_col_t                col_stg;
    gcn_pkg::score_t                  score [`GCN_NODES][`GCN_CLASSES];
    gcn_pkg::score_t                  max_r [`GCN_NODES];
    gcn_pkg::score_t                  max_nxt [`GCN_NODES];
    gcn_pkg::class_t [`GCN_NODES-1:0] best_r;
    gcn_pkg::class_t [`GCN_NODES-1:0] best_nxt;

    // pop and weight read go out together
    assign wt_re    = !agg.empty && (take_cnt < cnt_w'(`GCN_FEATS));
    assign agg.pop  = wt_re;
    assign wt_addr  = gcn_pkg::feat_addr_t'(take_cnt);
    assign last_acc = (acc_cnt == cnt_w'(`GCN_FEATS - 1));
    assign last_cls = (cls_cnt == gcn_pkg::class_t'(`GCN_CLASSES - 1));

    ////////////////////
    // argmax scan
    ////////////////////

    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            max_nxt[n]  = max_r[n];
            best_nxt[n] = best_r[n];
            // strictly greater, ties keep the lower class
            if (score[n][cls_cnt] > max_r[n]) begin
                max_nxt[n]  = score[n][cls_cnt];
                best_nxt[n] = cls_cnt;
            end
        end
    end

    ////////////////////
    // multiply-accumulate
    ////////////////////

    always_ff @(posedge clk) begin
        if (agg.pop) begin
            col_stg <= agg.pop_col;
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_CLASSES; c++) begin
                if (start) begin
                    score[n][c] <= '0;
                end else if (mac_vld) begin
                    score[n][c] <= score[n][c]
                        + gcn_pkg::score_t'(col_stg[n]) * gcn_pkg::score_t'(wt_row[c]);
                end
            end
            if (mac_vld && last_acc) begin
                max_r[n]  <= '0;
                best_r[n] <= '0;
            end else if (scan_act) begin
                max_r[n]  <= max_nxt[n];
                best_r[n] <= best_nxt[n];
            end
        end
    end

    // run control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            take_cnt <= '0;
            acc_cnt  <= '0;
            mac_vld  <= 1'b0;
            scan_act <= 1'b0;
            cls_cnt  <= '0;
            done     <= 1'b0;
            y        <= '0;
        end else if (start) begin
            take_cnt <= '0;
            acc_cnt  <= '0;
            mac_vld  <= 1'b0;
            scan_act <= 1'b0;
            cls_cnt  <= '0;
            done     <= 1'b0;
        end else begin
            mac_vld <= wt_re;
            if (wt_re) begin
                take_cnt <= take_cnt + 1'b1;
            end
            if (mac_vld) begin
                acc_cnt <= acc_cnt + 1'b1;
            end
            if (mac_vld && last_acc) begin
                scan_act <= 1'b1;
                cls_cnt  <= '0;
            end else if (scan_act) begin
                cls_cnt <= cls_cnt + 1'b1;
                // last class decides, results go straight out
                if (last_cls) begin
                    scan_act <= 1'b0;
                    y        <= best_nxt;
                    done     <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/gcn_top.sv ====
`timescale 1ns/1ps
`include "gcn_cfg.svh"

module gcn_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  gcn_pkg::node_id_t [`GCN_EDGES-1:0] coo_src,
    input  gcn_pkg::node_id_t [`GCN_EDGES-1:0] coo_dst,
    input  gcn_pkg::feat_col_t                 feat_col,
    input  gcn_pkg::weight_row_t               wt_row,
    output logic                               feat_re,
    output gcn_pkg::feat_addr_t                feat_addr,
    output logic                               wt_re,
    output gcn_pkg::feat_addr_t                wt_addr,
    output gcn_pkg::class_t [`GCN_NODES-1:0]   y,
    output logic                               done
);

    gcn_pkg::adj_mat_t adj;
    logic              adj_done;

    // aggregated columns, aggregator to scorer
    agg_col_if agg_if ();

    adjacency_builder u_adj (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .coo_src  (coo_src),
        .coo_dst  (coo_dst),
        .adj      (adj),
        .adj_done (adj_done)
    );

    neighbor_aggregator u_agg (
        .clk       (clk),
        .rst_n     (rst_n),
        .adj_done  (adj_done),
        .adj       (adj),
        .feat_col  (feat_col),
        .feat_re   (feat_re),
        .feat_addr (feat_addr),
        .agg       (agg_if.producer)
    );

    agg_col_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .agg   (agg_if.buffer)
    );

    class_scorer u_score (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .wt_row  (wt_row),
        .wt_re   (wt_re),
        .wt_addr (wt_addr),
        .y       (y),
        .done    (done),
        .agg     (agg_if.consumer)
    );

endmodule

// ==== dv/gcn_tb.sv ====
`timescale 1ns/1ps
`include "gcn_cfg.svh"

module gcn_tb;

    logic                               clk;
    logic                               rst_n;
    logic                               start;
    gcn_pkg::node_id_t [`GCN_EDGES-1:0] coo_src;
    gcn_pkg::node_id_t [`GCN_EDGES-1:0] coo_dst;
    gcn_pkg::feat_col_t                 feat_col;
    gcn_pkg::weight_row_t               wt_row;
    logic                               feat_re;
    gcn_pkg::feat_addr_t                feat_addr;
    logic                               wt_re;
    gcn_pkg::feat_addr_t                wt_addr;
    gcn_pkg::class_t [`GCN_NODES-1:0]   y;
    logic                               done;

    // memory contents and edge list of the current run
    gcn_pkg::feat_col_t                 feat_mem [`GCN_FEATS];
    gcn_pkg::weight_row_t               wt_mem [`GCN_FEATS];
    gcn_pkg::node_id_t [`GCN_EDGES-1:0] edge_src;
    gcn_pkg::node_id_t [`GCN_EDGES-1:0] edge_dst;
    gcn_pkg::feat_addr_t                feat_log [$];
    gcn_pkg::feat_addr_t                wt_log [$];
    int                                 seed;

    gcn_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .coo_src   (coo_src),
        .coo_dst   (coo_dst),
        .feat_col  (feat_col),
        .wt_row    (wt_row),
        .feat_re   (feat_re),
        .feat_addr (feat_addr),
        .wt_re     (wt_re),
        .wt_addr   (wt_addr),
        .y         (y),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // both memories answer one cycle after the strobe
    always @(posedge clk) begin
        if (feat_re) begin
            feat_col <= feat_mem[feat_addr];
            feat_log.push_back(feat_addr);
        end
        if (wt_re) begin
            wt_row <= wt_mem[wt_addr];
            wt_log.push_back(wt_addr);
        end
    end

    ////////////////////
    // checking
    ////////////////////

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_class(input string name, input gcn_pkg::class_t exp,
                               input gcn_pkg::class_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr_seq(input string name, input gcn_pkg::feat_addr_t exp_q[$],
                                  input gcn_pkg::feat_addr_t act_q[$]);
        if (act_q.size() != exp_q.size()) begin
            $display("%s: %0d reads seen where %0d were expected", name, act_q.size(),
                     exp_q.size());
            stop_run();
        end
        foreach (exp_q[i]) begin
            if (act_q[i] !== exp_q[i]) begin
                $display("ERROR %s: expected %0d, actual %0d", name, exp_q[i], act_q[i]);
                stop_run();
            end
        end
    endtask

    // adjacency, neighbour sums, scores and argmax with ties to the lowest class
    function automatic gcn_pkg::class_t [`GCN_NODES-1:0] model_classes(
        input gcn_pkg::node_id_t [`GCN_EDGES-1:0] src,
        input gcn_pkg::node_id_t [`GCN_EDGES-1:0] dst
    );
        bit                               nbr [`GCN_NODES][`GCN_NODES];
        int                               sums [`GCN_NODES][`GCN_FEATS];
        int                               score;
        int                               best;
        gcn_pkg::class_t [`GCN_NODES-1:0] res;
        foreach (nbr[n, k]) nbr[n][k] = 1'b0;
        for (int e = 0; e < `GCN_EDGES; e++) begin
            if (src[e] != 0 && dst[e] != 0) begin
                nbr[src[e] - 1][dst[e] - 1] = 1'b1;
                nbr[dst[e] - 1][src[e] - 1] = 1'b1;
            end
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int f = 0; f < `GCN_FEATS; f++) begin
                sums[n][f] = 0;
                for (int k = 0; k < `GCN_NODES; k++) begin
                    if (nbr[n][k]) sums[n][f] += int'(feat_mem[f][k]);
                end
            end
            res[n] = '0;
            best   = -1;
            for (int c = 0; c < `GCN_CLASSES; c++) begin
                score = 0;
                for (int f = 0; f < `GCN_FEATS; f++) score += sums[n][f] * int'(wt_mem[f][c]);
                if (score > best) begin
                    best   = score;
                    res[n] = gcn_pkg::class_t'(c);
                end
            end
        end
        return res;
    endfunction

    task automatic wait_done_low(input string name);
        int cycles;
        cycles = 0;
        while (done) begin
            @(posedge clk);
            cycles++;
            if (cycles > 4) begin
                $display("%s: done stayed high after start", name);
                stop_run();
            end
        end
    endtask

    task automatic wait_done_high(input string name);
        int cycles;
        cycles = 0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (cycles > 200) begin
                $display("%s: timed out waiting for done", name);
                stop_run();
            end
        end
    endtask

    // one start, then y and both read orders against the model
    task automatic run_graph(input string name);
        gcn_pkg::class_t [`GCN_NODES-1:0] exp_y;
        gcn_pkg::feat_addr_t              order_q [$];
        exp_y = model_classes(edge_src, edge_dst);
        for (int f = 0; f < `GCN_FEATS; f++) order_q.push_back(gcn_pkg::feat_addr_t'(f));
        @(posedge clk);
        feat_log.delete();
        wt_log.delete();
        start   <= 1'b1;
        coo_src <= edge_src;
        coo_dst <= edge_dst;
        @(posedge clk);
        start <= 1'b0;
        wait_done_low(name);
        wait_done_high(name);
        for (int n = 0; n < `GCN_NODES; n++) check_class(name, exp_y[n], y[n]);
        check_addr_seq({name, " feature reads"}, order_q, feat_log);
        check_addr_seq({name, " weight reads"}, order_q, wt_log);
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset();
        check_flag("reset feat_re", 1'b0, feat_re);
        check_flag("reset wt_re", 1'b0, wt_re);
        check_flag("reset done", 1'b0, done);
        for (int n = 0; n < `GCN_NODES; n++) check_class("reset y", '0, y[n]);
    endtask

    task automatic test_path_graph();
        // column f peaks at node f+1, each weight row favours one class
        for (int f = 0; f < `GCN_FEATS; f++) begin
            for (int k = 0; k < `GCN_NODES; k++) feat_mem[f][k] = (k == f) ? 5'd20 : 5'd1;
        end
        wt_mem[0] = {5'd1, 5'd1, 5'd10};
        wt_mem[1] = {5'd1, 5'd11, 5'd1};
        wt_mem[2] = {5'd12, 5'd1, 5'd1};
        wt_mem[3] = {5'd1, 5'd9, 5'd2};
        edge_src = {3'd0, 3'd0, 3'd0, 3'd3, 3'd2, 3'd1};
        edge_dst = {3'd0, 3'd0, 3'd0, 3'd4, 3'd3, 3'd2};
        run_graph("path graph");
    endtask

    task automatic test_degenerate_edges();
        edge_src = '0;
        edge_dst = '0;
        run_graph("no edges");
        for (int n = 0; n < `GCN_NODES; n++) check_class("no edges class 0", '0, y[n]);
        // self edge on node 2, edge 1-3 given twice, edge 2-3, two half-empty slots
        // node 3 lands in class 0 if the repeated edge were counted twice
        edge_src = {3'd4, 3'd0, 3'd2, 3'd3, 3'd1, 3'd2};
        edge_dst = {3'd0, 3'd5, 3'd3, 3'd1, 3'd3, 3'd2};
        run_graph("self and repeated edges");
    endtask

    task automatic test_random_runs();
        for (int r = 0; r < 8; r++) begin
            for (int e = 0; e < `GCN_EDGES; e++) begin
                edge_src[e] = gcn_pkg::node_id_t'($unsigned($random(seed)) % 7);
                edge_dst[e] = gcn_pkg::node_id_t'($unsigned($random(seed)) % 7);
            end
            for (int f = 0; f < `GCN_FEATS; f++) begin
                feat_mem[f] = gcn_pkg::feat_col_t'({$random(seed), $random(seed)});
                wt_mem[f]   = gcn_pkg::weight_row_t'($random(seed));
            end
            check_flag("random run done before start", 1'b1, done);
            run_graph($sformatf("random run %0d", r));
        end
    endtask

    initial begin
        seed     = 32'hc060df7c;
        rst_n    = 1'b0;
        start    = 1'b0;
        coo_src  = '0;
        coo_dst  = '0;
        feat_col = '0;
        wt_row   = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_reset();
        test_path_graph();
        test_degenerate_edges();
        test_random_runs();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
logic/gcn_pkg.sv
logic/agg_col_if.sv
logic/adjacency_builder.sv
logic/neighbor_aggregator.sv
logic/agg_col_fifo.sv
logic/class_scorer.sv
logic/gcn_top.sv
dv/gcn_tb.sv
